// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vlane_tb
FLIST     ?= vlane_top.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/vlane_cfg_pkg.sv ====
package vlane_cfg_pkg;

    // Reserved code 3 behaves as the smallest setting everywhere
    typedef enum logic [1:0] {
        LANES_1 = 2'd0,
        LANES_2 = 2'd1,
        LANES_4 = 2'd2
    } lanes_e;

    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2
    } lmul_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    typedef logic [1:0] pass_t;

    // log2 of the active lane count
    function automatic logic [1:0] lanes_log2(lanes_e l);
        return (l == LANES_2) ? 2'd1 : (l == LANES_4) ? 2'd2 : 2'd0;
    endfunction

    // log2 of the group size
    function automatic logic [1:0] lmul_log2(lmul_e m);
        return (m == LMUL_2) ? 2'd1 : (m == LMUL_4) ? 2'd2 : 2'd0;
    endfunction

endpackage

// ==== design/vlane_data_pkg.sv ====
`include "vlane_macros.svh"

package vlane_data_pkg;

    typedef enum logic [`VLANE_OP_W-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4
    } alu_op_e;

    // One slice word, seen per element width
    typedef union packed {
        logic [`VLANE_ELEN-1:0]               w;
        logic [`VLANE_ELEN/16-1:0][15:0]      h;
        logic [`VLANE_ELEN/8-1:0][7:0]        b;
    } elem_word_u;

    typedef logic [`VLANE_VLEN-1:0] vreg_t;

endpackage

// ==== design/vlane_datapath.sv ====
`timescale 1ns/1ps
`include "vlane_macros.svh"

module vlane_datapath (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       capture,
    input  logic                       wr_en,
    input  vlane_cfg_pkg::pass_t       pass,
    input  vlane_data_pkg::alu_op_e    op,
    input  vlane_cfg_pkg::sew_e        sew,
    input  vlane_cfg_pkg::lanes_e      lanes,
    input  vlane_cfg_pkg::lmul_e       lmul,
    input  vlane_data_pkg::vreg_t      op_a_0,
    input  vlane_data_pkg::vreg_t      op_a_1,
    input  vlane_data_pkg::vreg_t      op_a_2,
    input  vlane_data_pkg::vreg_t      op_a_3,
    input  vlane_data_pkg::vreg_t      op_b_0,
    input  vlane_data_pkg::vreg_t      op_b_1,
    input  vlane_data_pkg::vreg_t      op_b_2,
    input  vlane_data_pkg::vreg_t      op_b_3,
    output vlane_data_pkg::vreg_t      result_0,
    output vlane_data_pkg::vreg_t      result_1,
    output vlane_data_pkg::vreg_t      result_2,
    output vlane_data_pkg::vreg_t      result_3
);

    vlane_data_pkg::vreg_t   a_q [`VLANE_NUM_REGS];
    vlane_data_pkg::vreg_t   b_q [`VLANE_NUM_REGS];
    vlane_data_pkg::alu_op_e op_q;
    vlane_cfg_pkg::sew_e     sew_q;
    vlane_cfg_pkg::lanes_e   lanes_q;
    vlane_cfg_pkg::lmul_e    lmul_q;
    vlane_data_pkg::vreg_t   res_q [`VLANE_NUM_REGS];
    vlane_data_pkg::vreg_t   lane_y [`VLANE_NUM_LANES];
    logic [3:0]              lane_idx [`VLANE_NUM_LANES];
    logic                    lane_act [`VLANE_NUM_LANES];
    logic [3:0]              lane_cnt;
    logic [3:0]              grp_cnt;

    // Operand and config capture at the start of a request
    always_ff @(posedge clk) begin
        if (capture) begin
            a_q[0]  <= op_a_0;
            a_q[1]  <= op_a_1;
            a_q[2]  <= op_a_2;
            a_q[3]  <= op_a_3;
            b_q[0]  <= op_b_0;
            b_q[1]  <= op_b_1;
            b_q[2]  <= op_b_2;
            b_q[3]  <= op_b_3;
            op_q    <= op;
            sew_q   <= sew;
            lanes_q <= lanes;
            lmul_q  <= lmul;
        end
    end

    assign lane_cnt = 4'd1 << vlane_cfg_pkg::lanes_log2(lanes_q);
    assign grp_cnt  = 4'd1 << vlane_cfg_pkg::lmul_log2(lmul_q);

    ////////////////////////////////////////////////////////////
    // Lanes: register p*L + l, four slices each
    ////////////////////////////////////////////////////////////
    for (genvar l = 0; l < `VLANE_NUM_LANES; l++) begin : g_lane
        assign lane_idx[l] = (4'(pass) << vlane_cfg_pkg::lanes_log2(lanes_q)) + 4'(l);
        assign lane_act[l] = (4'(l) < lane_cnt) && (lane_idx[l] < grp_cnt);

        for (genvar s = 0; s < `VLANE_SLICES; s++) begin : g_slice
            vlane_elem_alu u_slice (
                .op  (op_q),
                .sew (sew_q),
                .a   (a_q[lane_idx[l][1:0]][s*`VLANE_ELEN +: `VLANE_ELEN]),
                .b   (b_q[lane_idx[l][1:0]][s*`VLANE_ELEN +: `VLANE_ELEN]),
                .y   (lane_y[l][s*`VLANE_ELEN +: `VLANE_ELEN])
            );
        end
    end

    // Write-back, one pass per cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int k = 0; k < `VLANE_NUM_REGS; k++) begin
                res_q[k] <= '0;
            end
        end else if (capture) begin
            for (int k = 0; k < `VLANE_NUM_REGS; k++) begin
                res_q[k] <= '0;
            end
        end else if (wr_en) begin
            for (int l = 0; l < `VLANE_NUM_LANES; l++) begin
                if (lane_act[l]) begin
                    res_q[lane_idx[l][1:0]] <= lane_y[l];
                end
            end
        end
    end

    assign result_0 = res_q[0];
    assign result_1 = res_q[1];
    assign result_2 = res_q[2];
    assign result_3 = res_q[3];

endmodule

// ==== design/vlane_elem_alu.sv ====
`timescale 1ns/1ps
`include "vlane_macros.svh"

module vlane_elem_alu (
    input  vlane_data_pkg::alu_op_e    op,
    input  vlane_cfg_pkg::sew_e        sew,
    input  vlane_data_pkg::elem_word_u a,
    input  vlane_data_pkg::elem_word_u b,
    output vlane_data_pkg::elem_word_u y
);

    logic                       is_arith;
    logic                       is_sub;
    vlane_data_pkg::elem_word_u arith;

    assign is_arith = (op == vlane_data_pkg::OP_ADD) || (op == vlane_data_pkg::OP_SUB);
    assign is_sub   = (op == vlane_data_pkg::OP_SUB);

    ////////////////////////////////////////////////////////////
    // Add and sub, each element on its own
    ////////////////////////////////////////////////////////////
    always_comb begin
        arith = '0;
        case (sew)
            vlane_cfg_pkg::SEW_32: begin
                arith.w = is_sub ? a.w - b.w : a.w + b.w;
            end
            vlane_cfg_pkg::SEW_16: begin
                for (int i = 0; i < `VLANE_ELEN/16; i++) begin
                    arith.h[i] = is_sub ? a.h[i] - b.h[i] : a.h[i] + b.h[i];
                end
            end
            default: begin
                // Bytes, also for the reserved code
                for (int i = 0; i < `VLANE_ELEN/8; i++) begin
                    arith.b[i] = is_sub ? a.b[i] - b.b[i] : a.b[i] + b.b[i];
                end
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////
    always_comb begin
        y = '0;
        if (is_arith) begin
            y = arith;
        end else begin
            case (op)
                vlane_data_pkg::OP_AND: y.w = a.w & b.w;
                vlane_data_pkg::OP_OR:  y.w = a.w | b.w;
                vlane_data_pkg::OP_XOR: y.w = a.w ^ b.w;
                default:                y.w = '0;
            endcase
        end
    end

endmodule

// ==== design/vlane_macros.svh ====
`ifndef VLANE_MACROS_SVH
`define VLANE_MACROS_SVH

// Register and slice widths
`define VLANE_VLEN 128
`define VLANE_ELEN 32

// Group and cluster sizes
`define VLANE_NUM_REGS 4
`define VLANE_NUM_LANES 4
`define VLANE_SLICES 4

`define VLANE_OP_W 3

`endif

// ==== design/vlane_sequencer.sv ====
`timescale 1ns/1ps

module vlane_sequencer (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  req,
    input  vlane_cfg_pkg::lanes_e lanes,
    input  vlane_cfg_pkg::lmul_e  lmul,
    output logic                  ack,
    output logic                  capture,
    output logic                  wr_en,
    output vlane_cfg_pkg::pass_t  pass
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE,
        S_REL
    } state_e;

    state_e               state;
    vlane_cfg_pkg::pass_t last_pass;
    vlane_cfg_pkg::pass_t last_pass_d;
    logic [1:0]           n_log;
    logic [1:0]           l_log;

    // P - 1 = ceil(n / L) - 1, from the requested config
    always_comb begin
        n_log = vlane_cfg_pkg::lmul_log2(lmul);
        l_log = vlane_cfg_pkg::lanes_log2(lanes);
        if (n_log > l_log) begin
            last_pass_d = vlane_cfg_pkg::pass_t'((3'd1 << (n_log - l_log)) - 3'd1);
        end else begin
            last_pass_d = '0;
        end
    end

    assign capture = (state == S_IDLE) && req;
    assign wr_en   = (state == S_RUN);

    ////////////////////////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= S_IDLE;
            pass      <= '0;
            last_pass <= '0;
            ack       <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state     <= S_RUN;
                        pass      <= '0;
                        last_pass <= last_pass_d;
                    end
                end
                S_RUN: begin
                    if (pass == last_pass) begin
                        state <= S_DONE;
                    end else begin
                        pass <= pass + 2'd1;
                    end
                end
                S_DONE: begin
                    state <= S_REL;
                    ack   <= 1'b1;
                end
                default: begin
                    // Hold ack until the host drops req
                    if (!req) begin
                        state <= S_IDLE;
                        ack   <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/vlane_top.sv ====
`timescale 1ns/1ps

module vlane_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    req,
    input  vlane_data_pkg::alu_op_e op,
    input  vlane_cfg_pkg::sew_e     sew,
    input  vlane_cfg_pkg::lmul_e    lmul,
    input  vlane_cfg_pkg::lanes_e   lanes,
    input  vlane_data_pkg::vreg_t   op_a_0,
    input  vlane_data_pkg::vreg_t   op_a_1,
    input  vlane_data_pkg::vreg_t   op_a_2,
    input  vlane_data_pkg::vreg_t   op_a_3,
    input  vlane_data_pkg::vreg_t   op_b_0,
    input  vlane_data_pkg::vreg_t   op_b_1,
    input  vlane_data_pkg::vreg_t   op_b_2,
    input  vlane_data_pkg::vreg_t   op_b_3,
    output logic                    ack,
    output vlane_data_pkg::vreg_t   result_0,
    output vlane_data_pkg::vreg_t   result_1,
    output vlane_data_pkg::vreg_t   result_2,
    output vlane_data_pkg::vreg_t   result_3
);

    logic                 capture;
    logic                 wr_en;
    vlane_cfg_pkg::pass_t pass;

    vlane_sequencer u_seq (
        .clk     (clk),
        .nrst    (nrst),
        .req     (req),
        .lanes   (lanes),
        .lmul    (lmul),
        .ack     (ack),
        .capture (capture),
        .wr_en   (wr_en),
        .pass    (pass)
    );

    vlane_datapath u_dp (
        .clk      (clk),
        .nrst     (nrst),
        .capture  (capture),
        .wr_en    (wr_en),
        .pass     (pass),
        .op       (op),
        .sew      (sew),
        .lanes    (lanes),
        .lmul     (lmul),
        .op_a_0   (op_a_0),
        .op_a_1   (op_a_1),
        .op_a_2   (op_a_2),
        .op_a_3   (op_a_3),
        .op_b_0   (op_b_0),
        .op_b_1   (op_b_1),
        .op_b_2   (op_b_2),
        .op_b_3   (op_b_3),
        .result_0 (result_0),
        .result_1 (result_1),
        .result_2 (result_2),
        .result_3 (result_3)
    );

endmodule

// ==== tb/vlane_assertions.sv ====
`timescale 1ns/1ps

module vlane_assertions (
    input logic clk,
    input logic nrst,
    input logic req,
    input logic ack,
    input logic capture,
    input logic wr_en
);

    // High from capture until the host releases the ack
    logic pending;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pending <= 1'b0;
        end else if (capture) begin
            pending <= 1'b1;
        end else if (ack && !req) begin
            pending <= 1'b0;
        end
    end

    ack_needs_capture: assert property (@(posedge clk) disable iff (!nrst)
        $rose(ack) |-> pending)
        else $error("ack rose without a captured request");

    capture_when_free: assert property (@(posedge clk) disable iff (!nrst)
        capture |-> (req && !ack))
        else $error("capture outside an open request");

    no_write_with_ack: assert property (@(posedge clk) disable iff (!nrst)
        !(wr_en && ack))
        else $error("wr_en high while ack is high");

    ack_holds: assert property (@(posedge clk) disable iff (!nrst)
        (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

endmodule

bind vlane_sequencer vlane_assertions u_seq_assert (
    .clk     (clk),
    .nrst    (nrst),
    .req     (req),
    .ack     (ack),
    .capture (capture),
    .wr_en   (wr_en)
);

// ==== tb/vlane_checker.sv ====
`timescale 1ns/1ps

module vlane_checker (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  req,
    input  logic                  ack,
    input  vlane_data_pkg::vreg_t result_0,
    input  vlane_data_pkg::vreg_t result_1,
    input  vlane_data_pkg::vreg_t result_2,
    input  vlane_data_pkg::vreg_t result_3,
    input  logic [8*16-1:0]       test_name,
    input  vlane_data_pkg::vreg_t exp_0,
    input  vlane_data_pkg::vreg_t exp_1,
    input  vlane_data_pkg::vreg_t exp_2,
    input  vlane_data_pkg::vreg_t exp_3,
    input  logic [2:0]            exp_passes,
    output int                    checks,
    output int                    errors
);

    vlane_data_pkg::vreg_t got [4];
    vlane_data_pkg::vreg_t want [4];
    vlane_data_pkg::vreg_t held [4];
    logic                  busy;
    logic                  acked;
    logic                  started;
    int                    cycles;

    assign got[0]  = result_0;
    assign got[1]  = result_1;
    assign got[2]  = result_2;
    assign got[3]  = result_3;
    assign want[0] = exp_0;
    assign want[1] = exp_1;
    assign want[2] = exp_2;
    assign want[3] = exp_3;

    initial begin
        checks = 0;
        errors = 0;
    end

    task automatic compare_word(input logic [8*16-1:0] label, input int k,
                                input vlane_data_pkg::vreg_t e,
                                input vlane_data_pkg::vreg_t a);
        checks++;
        if (a !== e) begin
            errors++;
            $display("error: test %0s result_%0d expected %h actual %h", label, k, e, a);
        end
    endtask

    // Idle state after reset
    task automatic check_idle();
        checks++;
        if (ack !== 1'b0) begin
            errors++;
            $display("The ack output was high after reset before any request");
        end
        for (int k = 0; k < 4; k++) begin
            compare_word("reset", k, '0, got[k]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Handshake tracking per cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!nrst) begin
            busy    = 1'b0;
            acked   = 1'b0;
            started = 1'b0;
            cycles  = 0;
            check_idle();
        end else begin
            if (!started && !req) begin
                check_idle();
            end
            if (req) begin
                started = 1'b1;
            end
            if (busy) begin
                cycles++;
            end
            if (!busy && req && !ack) begin
                // Next rising edge is E0
                busy   = 1'b1;
                acked  = 1'b0;
                cycles = -1;
            end else if (busy && ack && !acked) begin
                acked = 1'b1;
                checks++;
                if (cycles != int'(exp_passes) + 1) begin
                    errors++;
                    $display("Test %0s: ack rose after %0d cycles, %0d expected",
                             test_name, cycles, int'(exp_passes) + 1);
                end
                for (int k = 0; k < 4; k++) begin
                    compare_word(test_name, k, want[k], got[k]);
                    held[k] = got[k];
                end
            end else if (busy && acked) begin
                if (ack) begin
                    for (int k = 0; k < 4; k++) begin
                        checks++;
                        if (got[k] !== held[k]) begin
                            errors++;
                            $display("Test %0s: result_%0d changed while ack was held",
                                     test_name, k);
                        end
                    end
                end else begin
                    checks++;
                    if (req) begin
                        errors++;
                        $display("Test %0s: ack fell while req was still high", test_name);
                    end
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

// ==== tb/vlane_input.txt ====
# name op sew lmul lanes a0 a1 a2 a3 b0 b1 b2 b3 r0 r1 r2 r3 passes (hex)
# codes: op add=0 sub=1 and=2 or=3 xor=4, sew 8/16/32=0/1/2, lmul and lanes 1/2/4=0/1/2
add32 0 2 0 0 00000001000000020000000380000000 1 2 3 00000010000000200000003080000000 1 1 1 00000011000000220000003300000000 0 0 0 1
sub32 1 2 0 0 0000000a00000000ffffffff00000001 1 2 3 00000003000000010000000100000002 1 1 1 00000007fffffffffffffffeffffffff 0 0 0 1
and32 2 2 0 0 ff00ff00ff00ff00ff00ff00ff00ff00 1 2 3 0ff00ff00ff00ff00ff00ff00ff00ff0 1 1 1 0f000f000f000f000f000f000f000f00 0 0 0 1
or32 3 2 0 0 ff00ff00ff00ff00ff00ff00ff00ff00 1 2 3 0ff00ff00ff00ff00ff00ff00ff00ff0 1 1 1 fff0fff0fff0fff0fff0fff0fff0fff0 0 0 0 1
xor32 4 2 0 0 ff00ff00ff00ff00ff00ff00ff00ff00 1 2 3 0ff00ff00ff00ff00ff00ff00ff00ff0 1 1 1 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 0 0 0 1
add8 0 0 0 0 ff7f80feff7f80feff7f80feff7f80fe 1 2 3 01018003010180030101800301018003 1 1 1 00800001008000010080000100800001 0 0 0 1
sub16 1 1 0 0 00008000000080000000800000008000 1 2 3 00010001000100010001000100010001 1 1 1 ffff7fffffff7fffffff7fffffff7fff 0 0 0 1
add16 0 1 0 0 ffff7fffffff7fffffff7fffffff7fff 1 2 3 00010001000100010001000100010001 1 1 1 00008000000080000000800000008000 0 0 0 1
m4_l1 0 2 2 0 1 2 3 4 10 20 30 40 11 22 33 44 4
m4_l2 4 0 2 1 ff 0f f0 aa 0f 0f 0f 55 f0 0 ff ff 2
m4_l4 1 2 2 2 10 20 30 40 1 2 3 4 f 1e 2d 3c 1
m2_l4 3 2 1 2 1 2 4 8 10 20 40 80 11 22 0 0 1

// ==== tb/vlane_tb.sv ====
`timescale 1ns/1ps

module vlane_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int MAX_VEC      = 32;

    logic                    clk;
    logic                    nrst;
    logic                    req;
    logic                    ack;
    vlane_data_pkg::alu_op_e op;
    vlane_cfg_pkg::sew_e     sew;
    vlane_cfg_pkg::lmul_e    lmul;
    vlane_cfg_pkg::lanes_e   lanes;
    vlane_data_pkg::vreg_t   op_a_0, op_a_1, op_a_2, op_a_3;
    vlane_data_pkg::vreg_t   op_b_0, op_b_1, op_b_2, op_b_3;
    vlane_data_pkg::vreg_t   result_0, result_1, result_2, result_3;
    vlane_data_pkg::vreg_t   exp_0, exp_1, exp_2, exp_3;
    logic [8*16-1:0]         test_name;
    logic [2:0]              exp_passes;
    int                      checks;
    int                      errors;
    int                      num_vec;
    int                      seed;
    logic                    loaded;

    // Vector storage, config columns are op, sew, lmul, lanes, passes
    logic [8*16-1:0]         name_mem [MAX_VEC];
    logic [3:0]              cfg_mem [MAX_VEC][5];
    vlane_data_pkg::vreg_t   a_mem [MAX_VEC][4];
    vlane_data_pkg::vreg_t   b_mem [MAX_VEC][4];
    vlane_data_pkg::vreg_t   r_mem [MAX_VEC][4];

    vlane_top i_dut (
        .clk (clk), .nrst (nrst), .req (req), .op (op), .sew (sew), .lmul (lmul),
        .lanes (lanes),
        .op_a_0 (op_a_0), .op_a_1 (op_a_1), .op_a_2 (op_a_2), .op_a_3 (op_a_3),
        .op_b_0 (op_b_0), .op_b_1 (op_b_1), .op_b_2 (op_b_2), .op_b_3 (op_b_3),
        .ack (ack),
        .result_0 (result_0), .result_1 (result_1),
        .result_2 (result_2), .result_3 (result_3)
    );

    vlane_checker u_checker (
        .clk (clk), .nrst (nrst), .req (req), .ack (ack),
        .result_0 (result_0), .result_1 (result_1),
        .result_2 (result_2), .result_3 (result_3),
        .test_name (test_name),
        .exp_0 (exp_0), .exp_1 (exp_1), .exp_2 (exp_2), .exp_3 (exp_3),
        .exp_passes (exp_passes), .checks (checks), .errors (errors)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic read_vectors();
        int                    fd;
        int                    n;
        string                 line;
        logic [8*16-1:0]       nm;
        logic [31:0]           f [5];
        vlane_data_pkg::vreg_t v [12];
        fd = $fopen("tb/vlane_input.txt", "r");
        if (fd == 0) begin
            $display("The vector file tb/vlane_input.txt could not be opened");
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == 8'h23) continue;
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        nm, f[0], f[1], f[2], f[3], v[0], v[1], v[2], v[3], v[4], v[5],
                        v[6], v[7], v[8], v[9], v[10], v[11], f[4]);
            if (n == 18) begin
                name_mem[num_vec] = nm;
                for (int i = 0; i < 5; i++) cfg_mem[num_vec][i] = f[i][3:0];
                for (int k = 0; k < 4; k++) begin
                    a_mem[num_vec][k] = v[k];
                    b_mem[num_vec][k] = v[k+4];
                    r_mem[num_vec][k] = v[k+8];
                end
                num_vec++;
            end
        end
        $fclose(fd);
    endtask

    // One four-phase transaction with random hold and gap
    task automatic run_vector(input int t);
        int hold;
        int gap;
        hold = $random(seed) & 3;
        gap  = $random(seed) & 3;
        @(posedge clk);
        #DRIVE_DELAY;
        op         = vlane_data_pkg::alu_op_e'(cfg_mem[t][0][2:0]);
        sew        = vlane_cfg_pkg::sew_e'(cfg_mem[t][1][1:0]);
        lmul       = vlane_cfg_pkg::lmul_e'(cfg_mem[t][2][1:0]);
        lanes      = vlane_cfg_pkg::lanes_e'(cfg_mem[t][3][1:0]);
        exp_passes = cfg_mem[t][4][2:0];
        test_name  = name_mem[t];
        {op_a_0, op_a_1, op_a_2, op_a_3} = {a_mem[t][0], a_mem[t][1], a_mem[t][2], a_mem[t][3]};
        {op_b_0, op_b_1, op_b_2, op_b_3} = {b_mem[t][0], b_mem[t][1], b_mem[t][2], b_mem[t][3]};
        {exp_0, exp_1, exp_2, exp_3} = {r_mem[t][0], r_mem[t][1], r_mem[t][2], r_mem[t][3]};
        req = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!ack);
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (ack);
        repeat (gap) @(posedge clk);
    endtask

    initial begin
        seed    = 41925;
        nrst    = 1'b0;
        req     = 1'b0;
        loaded  = 1'b0;
        num_vec = 0;
        op      = vlane_data_pkg::OP_ADD;
        sew     = vlane_cfg_pkg::SEW_8;
        lmul    = vlane_cfg_pkg::LMUL_1;
        lanes   = vlane_cfg_pkg::LANES_1;
        {op_a_0, op_a_1, op_a_2, op_a_3} = '0;
        {op_b_0, op_b_1, op_b_2, op_b_3} = '0;
        {exp_0, exp_1, exp_2, exp_3} = '0;
        exp_passes = '0;
        test_name  = "reset";
        read_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY nrst = 1'b1;
        repeat (2) @(posedge clk);
        for (int t = 0; t < num_vec; t++) begin
            run_vector(t);
        end
        repeat (4) @(posedge clk);
        $display("Vectors: %0d, checks: %0d, errors: %0d", num_vec, checks, errors);
        if (errors == 0 && num_vec > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog, sized by the number of vectors
    initial begin
        wait (loaded);
        #((num_vec * 16 + RESET_CYCLES + 8) * CLK_PERIOD);
        $display("Timeout: the DUT did not complete all requests in time");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== vlane_top.f ====
+incdir+design
design/vlane_cfg_pkg.sv
design/vlane_data_pkg.sv
design/vlane_elem_alu.sv
design/vlane_sequencer.sv
design/vlane_datapath.sv
design/vlane_top.sv
tb/vlane_assertions.sv
tb/vlane_checker.sv
tb/vlane_tb.sv
